//--- rtl/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

// feature map size, one frame streamed row-major
`define CONV_IMG_W 8
`define CONV_IMG_H 6

// kernel side, stride 1, no padding
`define CONV_K 3

// data widths
`define CONV_PIX_W 8   // pixels, weights, bias and output
`define CONV_ACC_W 20  // window sum, 9 products of 16 bits

// E scale, multiply by tail then shift right by rank
`define CONV_TAIL_W 16
`define CONV_RANK_W 5

`endif

//--- rtl/conv_pkg.sv
`default_nettype none

package conv_pkg;

    `include "conv_consts.svh"

    ////////////////////////////////////////
    // pixel and weight data
    ////////////////////////////////////////

    typedef logic signed [`CONV_PIX_W-1:0] pixel_t;
    typedef logic signed [`CONV_PIX_W-1:0] weight_t;

    // [row][col], row 0 is the oldest image row, col K-1 the newest column
    typedef pixel_t [0:`CONV_K-1][0:`CONV_K-1] window_t;
    typedef weight_t [0:`CONV_K-1][0:`CONV_K-1] weight_set_t;

    typedef logic signed [`CONV_ACC_W-1:0] acc_t;

    ////////////////////////////////////////
    // requantization
    ////////////////////////////////////////

    typedef logic signed [`CONV_PIX_W-1:0] bias_t;
    typedef logic [`CONV_TAIL_W-1:0] tail_t;        // unsigned multiplier
    typedef logic [`CONV_RANK_W-1:0] rank_t;        // right shift count
    typedef logic signed [`CONV_PIX_W-1:0] qpix_t;  // saturated result

    typedef logic [$clog2(`CONV_K*`CONV_K)-1:0] widx_t;  // 0 to 8

endpackage

`default_nettype wire

//--- rtl/pipe_ctrl_if.sv
`default_nettype none

// strobes from the controller to the datapath stages
interface pipe_ctrl_if import conv_pkg::*; ();

    logic  pix_shift;  // accepted pixel, shift line buffers and window
    logic  win_valid;  // window register holds a full window
    logic  acc_valid;  // mac sum ready
    logic  w_we;       // weight write
    widx_t w_idx;      // weight slot for w_we

    modport ctrl (
        output pix_shift,
        output win_valid,
        output acc_valid,
        output w_we,
        output w_idx
    );

    modport dp (
        input pix_shift,
        input win_valid,
        input acc_valid,
        input w_we,
        input w_idx
    );

endinterface

`default_nettype wire

//--- rtl/conv_ctrl.sv
`default_nettype none

`include "conv_consts.svh"

module conv_ctrl import conv_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             pix_valid,
    input  logic             w_valid,
    pipe_ctrl_if.ctrl        ctl,
    output logic             out_valid,
    output logic             out_last
);

    localparam int COL_W   = $clog2(`CONV_IMG_W);
    localparam int ROW_W   = $clog2(`CONV_IMG_H);
    localparam int MAC_LAT = 2;  // win_valid to acc_valid
    localparam int DEPTH   = 4;  // win_valid to out_valid

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             col_end;
    logic             row_end;
    logic             win_done;    // current pixel closes a window
    logic             frame_done;  // current pixel closes the frame
    logic [DEPTH:0]   v_pipe;
    logic [DEPTH:0]   l_pipe;
    widx_t            w_idx_r;

    ////////////////////////////////////////
    // pixel position in the frame
    ////////////////////////////////////////

    assign col_end    = (col == COL_W'(`CONV_IMG_W - 1));
    assign row_end    = (row == ROW_W'(`CONV_IMG_H - 1));
    assign win_done   = (col >= COL_W'(`CONV_K - 1)) && (row >= ROW_W'(`CONV_K - 1));
    assign frame_done = col_end && row_end;

    always_ff @(posedge clk) begin
        if (reset) begin
            col <= '0;
            row <= '0;
        end else if (pix_valid) begin
            if (col_end) begin
                col <= '0;
                if (row_end)
                    row <= '0;  // next frame
                else
                    row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // valid and last delay chains
    ////////////////////////////////////////

    // bit 0 is win_valid, one bit per pipeline stage after it
    always_ff @(posedge clk) begin
        if (reset) begin
            v_pipe <= '0;
            l_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[DEPTH-1:0], pix_valid && win_done};
            l_pipe <= {l_pipe[DEPTH-1:0], pix_valid && frame_done};
        end
    end

    ////////////////////////////////////////
    // weight write index
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            w_idx_r <= '0;
        end else if (w_valid) begin
            if (w_idx_r == widx_t'(`CONV_K * `CONV_K - 1))
                w_idx_r <= '0;
            else
                w_idx_r <= w_idx_r + 1'b1;
        end
    end

    // shift and weight write happen on the same edge as the input
    assign ctl.pix_shift = pix_valid;
    assign ctl.w_we      = w_valid;
    assign ctl.w_idx     = w_idx_r;
    assign ctl.win_valid = v_pipe[0];
    assign ctl.acc_valid = v_pipe[MAC_LAT];

    assign out_valid = v_pipe[DEPTH];
    assign out_last  = l_pipe[DEPTH];  // last window of the frame

endmodule

`default_nettype wire

//--- rtl/line_window.sv
`default_nettype none

`include "conv_consts.svh"

module line_window import conv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  pixel_t    pix_data,
    pipe_ctrl_if.dp   ctl,
    output window_t   win
);

    localparam int W   = `CONV_IMG_W;
    localparam int NEW = `CONV_K - 1;  // newest row and column

    // line1 tap is one image row old, line2 tap two rows
    pixel_t [W-1:0] line1;
    pixel_t [W-1:0] line2;
    pixel_t         tap1;
    pixel_t         tap2;

    assign tap1 = line1[W-1];
    assign tap2 = line2[W-1];

    ////////////////////////////////////////
    // row delay lines
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ctl.pix_shift) begin
            line1 <= {line1[W-2:0], pix_data};
            line2 <= {line2[W-2:0], tap1};  // cascaded behind line1
        end
    end

    ////////////////////////////////////////
    // 3x3 window
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            win <= '0;
        end else if (ctl.pix_shift) begin
            // older columns move left
            for (int r = 0; r < `CONV_K; r++) begin
                for (int c = 0; c < NEW; c++) begin
                    win[r][c] <= win[r][c+1];
                end
            end
            // new column, top is the oldest row
            win[0][NEW]     <= tap2;
            win[1][NEW]     <= tap1;
            win[NEW][NEW]   <= pix_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/conv_mac.sv
`default_nettype none

`include "conv_consts.svh"

module conv_mac import conv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  weight_t   w_data,
    input  window_t   win,
    pipe_ctrl_if.dp   ctl,
    output acc_t      acc
);

    localparam int PROD_W = 2 * `CONV_PIX_W;

    weight_set_t             weights;
    logic signed [PROD_W-1:0] prod [`CONV_K][`CONV_K];
    acc_t                    row_sum [`CONV_K];
    acc_t                    sum_c;

    ////////////////////////////////////////
    // weight registers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            weights <= '0;
        end else if (ctl.w_we) begin
            for (int r = 0; r < `CONV_K; r++) begin
                for (int c = 0; c < `CONV_K; c++) begin
                    if (ctl.w_idx == widx_t'(r * `CONV_K + c))
                        weights[r][c] <= w_data;  // row-major slot
                end
            end
        end
    end

    ////////////////////////////////////////
    // stage 1, nine signed products
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ctl.win_valid) begin
            for (int r = 0; r < `CONV_K; r++) begin
                for (int c = 0; c < `CONV_K; c++) begin
                    prod[r][c] <= win[r][c] * weights[r][c];
                end
            end
        end
    end

    ////////////////////////////////////////
    // stage 2, adder tree
    ////////////////////////////////////////

    // products hold between windows, so the sum stays put during gaps
    always_comb begin
        sum_c = '0;
        for (int r = 0; r < `CONV_K; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < `CONV_K; c++) begin
                row_sum[r] = row_sum[r] + acc_t'(prod[r][c]);  // sign extend
            end
            sum_c = sum_c + row_sum[r];
        end
    end

    always_ff @(posedge clk) begin
        acc <= sum_c;
    end

endmodule

`default_nettype wire

//--- rtl/bias_scale.sv
`default_nettype none

`include "conv_consts.svh"

module bias_scale import conv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  acc_t      acc,
    input  bias_t     bias,
    input  tail_t     tail,
    input  rank_t     rank,
    pipe_ctrl_if.dp   ctl,
    output qpix_t     q
);

    localparam int SUM_W  = `CONV_ACC_W + 1;           // one bit for the bias add
    localparam int PROD_W = SUM_W + `CONV_TAIL_W + 1;  // tail gets a zero sign bit
    localparam int Q_MAX  = 2 ** (`CONV_PIX_W - 1) - 1;
    localparam int Q_MIN  = -(2 ** (`CONV_PIX_W - 1));

    logic signed [SUM_W-1:0]  biased;
    logic signed [PROD_W-1:0] scaled_r;
    logic signed [PROD_W-1:0] shifted;
    rank_t                    rank_r;

    assign biased = acc + bias;

    ////////////////////////////////////////
    // stage 1, bias add and tail multiply
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (ctl.acc_valid) begin
            scaled_r <= biased * $signed({1'b0, tail});
            rank_r   <= rank;  // rank travels with its product
        end
    end

    ////////////////////////////////////////
    // stage 2, rank shift and saturation
    ////////////////////////////////////////

    // arithmetic shift floors toward minus infinity
    assign shifted = scaled_r >>> rank_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (shifted > Q_MAX) begin
            q <= qpix_t'(Q_MAX);
        end else if (shifted < Q_MIN) begin
            q <= qpix_t'(Q_MIN);
        end else begin
            q <= qpix_t'(shifted);
        end
    end

endmodule

`default_nettype wire

//--- rtl/conv_datapath.sv
`default_nettype none

`include "conv_consts.svh"

module conv_datapath import conv_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    pix_valid,
    input  logic [`CONV_PIX_W-1:0]  pix_data,
    input  logic                    w_valid,
    input  logic [`CONV_PIX_W-1:0]  w_data,
    input  logic [`CONV_PIX_W-1:0]  bias,
    input  logic [`CONV_TAIL_W-1:0] tail,
    input  logic [`CONV_RANK_W-1:0] rank,
    output logic                    out_valid,
    output logic                    out_last,
    output logic [`CONV_PIX_W-1:0]  out_data
);

    window_t win;
    acc_t    acc;

    pipe_ctrl_if ctl_if ();

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    conv_ctrl i_ctrl (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .w_valid   (w_valid),
        .ctl       (ctl_if.ctrl),
        .out_valid (out_valid),
        .out_last  (out_last)
    );

    ////////////////////////////////////////
    // window, mac, requantization
    ////////////////////////////////////////

    line_window i_window (
        .clk      (clk),
        .reset    (reset),
        .pix_data (pix_data),
        .ctl      (ctl_if.dp),
        .win      (win)
    );

    conv_mac i_mac (
        .clk    (clk),
        .reset  (reset),
        .w_data (w_data),
        .win    (win),
        .ctl    (ctl_if.dp),
        .acc    (acc)
    );

    bias_scale i_scale (
        .clk   (clk),
        .reset (reset),
        .acc   (acc),
        .bias  (bias),
        .tail  (tail),
        .rank  (rank),
        .ctl   (ctl_if.dp),
        .q     (out_data)
    );

endmodule

`default_nettype wire

//--- testbench/conv_asserts.sv
`default_nettype none

module conv_asserts (
    input logic clk,
    input logic reset,
    input logic pix_valid,
    input logic w_valid,
    input logic out_valid,
    input logic out_last
);

    int n_fail = 0;

    // one reset edge clears the output strobe
    a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            n_fail++;
            $error("out_valid high while reset is applied");
        end

    a_last_valid: assert property (@(posedge clk) disable iff (reset) out_last |-> out_valid)
        else begin
            n_fail++;
            $error("out_last high without out_valid");
        end

    // high after the 4th edge past the pixel edge, so seen 5 samples later
    a_latency: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(pix_valid, 5))
        else begin
            n_fail++;
            $error("out_valid without an accepted pixel 4 cycles before");
        end

    a_known: assert property (@(posedge clk) !$isunknown({pix_valid, w_valid}))
        else begin
            n_fail++;
            $error("pix_valid or w_valid unknown");
        end

endmodule

bind conv_datapath conv_asserts i_asserts (
    .clk       (clk),
    .reset     (reset),
    .pix_valid (pix_valid),
    .w_valid   (w_valid),
    .out_valid (out_valid),
    .out_last  (out_last)
);

`default_nettype wire

//--- testbench/conv_tb.sv
`default_nettype none

`include "conv_consts.svh"

module conv_tb import conv_pkg::*; ();

    localparam int W        = `CONV_IMG_W;
    localparam int H        = `CONV_IMG_H;
    localparam int KM       = `CONV_K - 1;
    localparam int NW       = `CONV_K * `CONV_K;
    localparam int LAT      = 4;
    localparam int FRAMES   = 8;  // frames over all tests
    localparam int WATCHDOG = FRAMES * W * H * 4 + 200;

    logic    clk = 1'b0;
    logic    reset;
    logic    pix_valid;
    pixel_t  pix_data;
    logic    w_valid;
    weight_t w_data;
    bias_t   bias;
    tail_t   tail;
    rank_t   rank;
    logic    out_valid;
    logic    out_last;
    logic [`CONV_PIX_W-1:0] out_data;

    int          seed = 83;
    int          cycle = 0;
    int          n_pass = 0;
    int          n_err = 0;
    int          n_res = 0;
    int          err0 = 0;
    int          res0 = 0;
    string       cur_test = "reset";
    weight_set_t model_w = '0;
    int          model_widx = 0;
    pixel_t      frame_pix [H][W];
    qpix_t       exp_q [$];     // expected results in window order
    logic        exp_last [$];
    int          exp_due [$];   // cycle the result must show up

    conv_datapath i_dut (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .w_valid   (w_valid),
        .w_data    (w_data),
        .bias      (bias),
        .tail      (tail),
        .rank      (rank),
        .out_valid (out_valid),
        .out_last  (out_last),
        .out_data  (out_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////

    function automatic int rand_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // 0 full range, 1 extremes, 2 non-negative, 3 negative
    function automatic pixel_t rand_value(int mode);
        case (mode)
            1: return (rand_range(0, 1) == 1) ? pixel_t'(127) : pixel_t'(-128);
            2: return pixel_t'(rand_range(0, 127));
            3: return pixel_t'(rand_range(-128, -1));
            default: return pixel_t'(rand_range(-128, 127));
        endcase
    endfunction

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic int window_sum(int row, int col);
        int s;
        s = 0;
        for (int r = 0; r < `CONV_K; r++) begin
            for (int c = 0; c < `CONV_K; c++) begin
                s += int'(frame_pix[row-KM+r][col-KM+c]) * int'(model_w[r][c]);
            end
        end
        return s;
    endfunction

    // bias, times tail, floor shift by rank, clamp
    function automatic qpix_t requant(int sum);
        longint scaled;
        longint t;
        longint b;
        t = tail;  // zero extended
        b = bias;
        scaled = (longint'(sum) + b) * t;
        scaled = scaled >>> rank;
        if (scaled > 127)
            return qpix_t'(127);
        if (scaled < -128)
            return qpix_t'(-128);
        return qpix_t'(scaled);
    endfunction

    ////////////////////////////////////////
    // compare and monitor
    ////////////////////////////////////////

    task automatic check_q(string name, qpix_t exp, qpix_t act);
        if (act === exp) begin
            n_pass++;
        end else begin
            n_err++;
            $display("error %s: out_data expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_last(string name, logic exp, logic act);
        if (act === exp) begin
            n_pass++;
        end else begin
            n_err++;
            $display("error %s: out_last expected %b actual %b", name, exp, act);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    n_err++;
                    $display("%s: out_valid high with no window waiting", cur_test);
                end else begin
                    if (exp_due[0] != cycle) begin
                        n_err++;
                        $display("%s: result came at cycle %0d, its window set cycle %0d",
                                 cur_test, cycle, exp_due[0]);
                    end
                    check_q(cur_test, exp_q.pop_front(), qpix_t'(out_data));
                    check_last(cur_test, exp_last.pop_front(), out_last);
                    void'(exp_due.pop_front());
                    n_res++;
                end
            end else if (exp_q.size() != 0 && exp_due[0] < cycle) begin
                n_err++;
                $display("%s: no result at cycle %0d for a completed window",
                         cur_test, exp_due[0]);
                void'(exp_q.pop_front());
                void'(exp_last.pop_front());
                void'(exp_due.pop_front());
            end
        end
    end

    ////////////////////////////////////////
    // drivers
    ////////////////////////////////////////

    task automatic load_weights(int n, int mode);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            w_valid = 1'b1;
            w_data  = rand_value(mode);
            model_w[model_widx / `CONV_K][model_widx % `CONV_K] = w_data;
            model_widx = (model_widx + 1) % NW;  // wraps like the DUT index
        end
        @(negedge clk);
        w_valid = 1'b0;
    endtask

    // one frame, up to gap_max idle cycles before each pixel
    task automatic run_frame(int pmode, int gap_max);
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                repeat (rand_range(0, gap_max)) begin
                    @(negedge clk);
                    pix_valid = 1'b0;
                    pix_data  = rand_value(0);  // junk, not accepted
                end
                @(negedge clk);
                pix_valid = 1'b1;
                pix_data  = rand_value(pmode);
                frame_pix[r][c] = pix_data;
                if (r >= KM && c >= KM) begin
                    exp_q.push_back(requant(window_sum(r, c)));
                    exp_last.push_back(r == H - 1 && c == W - 1);
                    exp_due.push_back(cycle + 1 + LAT);  // accepted on the next edge
                end
            end
        end
        @(negedge clk);
        pix_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic begin_test(string name);
        cur_test = name;
        err0 = n_err;
        res0 = n_res;
    endtask

    task automatic end_test();
        drain();
        $display("%-14s results %0d, errors %0d", cur_test, n_res - res0, n_err - err0);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        reset     = 1'b1;
        pix_valid = 1'b0;
        pix_data  = '0;
        w_valid   = 1'b0;
        w_data    = '0;
        bias      = '0;
        tail      = '0;
        rank      = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        begin_test("back_to_back");
        load_weights(NW, 0);
        bias = bias_t'(rand_range(-20, 20));
        tail = tail_t'(rand_range(8, 32));
        rank = rank_t'(rand_range(10, 12));
        run_frame(0, 0);
        end_test();

        begin_test("gapped");
        run_frame(0, 3);
        end_test();

        begin_test("saturation");
        load_weights(NW, 1);
        bias = '0;
        tail = '1;
        rank = '0;
        run_frame(1, 1);
        end_test();

        // negative sums, floor shift
        begin_test("rank_sweep");
        load_weights(NW, 3);
        bias = bias_t'(rand_range(-20, -1));
        for (int i = 0; i < 4; i++) begin
            tail = tail_t'(rand_range(20, 60));
            rank = rank_t'(14 + 2 * i);
            run_frame(2, 1);
            drain();
        end
        end_test();

        begin_test("weight_reload");
        load_weights(NW + 4, 0);  // index ends past the wrap
        bias = bias_t'(rand_range(-20, 20));
        tail = tail_t'(rand_range(8, 32));
        rank = rank_t'(rand_range(10, 12));
        run_frame(0, 2);
        end_test();

        $display("results %0d, checks passed %0d, errors %0d, assertion failures %0d",
                 n_res, n_pass, n_err, i_dut.i_asserts.n_fail);
        if (n_err == 0 && i_dut.i_asserts.n_fail == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", WATCHDOG);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+rtl
rtl/conv_pkg.sv
rtl/pipe_ctrl_if.sv
rtl/conv_ctrl.sv
rtl/line_window.sv
rtl/conv_mac.sv
rtl/bias_scale.sv
rtl/conv_datapath.sv
testbench/conv_asserts.sv
testbench/conv_tb.sv
